// File: mpu_defines.svh
`ifndef MPU_DEFINES_SVH
`define MPU_DEFINES_SVH

// Opcodes, low nibble of the first instruction byte.
`define MPU_OP_NOP   4'd0
`define MPU_OP_LOAD  4'd1
`define MPU_OP_MLOAD 4'd2
`define MPU_OP_INT   4'd3
`define MPU_OP_JMP   4'd4
`define MPU_OP_CMP   4'd5
`define MPU_OP_LT    4'd6
`define MPU_OP_MASK  4'd7

// Operand kinds, one bit per operand in the second byte.
`define MPU_KIND_REG 1'b0 // One byte, index and selector.
`define MPU_KIND_IMM 1'b1 // Two bytes, little endian.

`define MPU_NREGS     32 // Register file depth.
`define MPU_IDX_W     5  // Register index width.
`define MPU_SEL_W     3  // Sub-register selector width.
`define MPU_XLEN      64 // Register and operand width.
`define MPU_IP_W      16 // Instruction pointer width.
`define MPU_WIN_BYTES 10 // Bytes visible at prog_addr.

`endif

// File: mpu_pkg.sv
`default_nettype none

package mpu_pkg;

  `include "mpu_defines.svh"

  // One decoded operand.
  typedef struct packed {
    logic [`MPU_XLEN-1:0]  value; // Immediate or register contents.
    logic [`MPU_IDX_W-1:0] idx;   // Register index, zero for immediates.
    logic [`MPU_SEL_W-1:0] sel;   // Sub-register selector.
  } mpu_operand_t;

  // Instruction as seen by the execution block.
  typedef struct packed {
    logic [3:0]            op;
    logic [1:0]            size;  // 8, 16, 32 or 64 bit compare width.
    logic [`MPU_IP_W-1:0]  isize; // Length in bytes.
    mpu_operand_t [3:0]    opnd;
  } mpu_instr_t;

  // Single register write port.
  typedef struct packed {
    logic [`MPU_IDX_W-1:0] idx;
    logic [`MPU_XLEN-1:0]  data;
    logic                  we;
  } mpu_wreg_t;

  // Next ip request.
  typedef struct packed {
    logic [`MPU_IP_W-1:0] ip_incr; // Used when no jump is taken.
    logic                 ip_load;
    logic [`MPU_IP_W-1:0] ip_data; // Jump target.
  } mpu_ip_cmd_t;

endpackage

`default_nettype wire

// File: mpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpu_defines.svh"

module mpu_alu (
  input  logic [1:0]            size,
  input  logic [3:0]            op,
  input  mpu_pkg::mpu_operand_t o0,
  input  mpu_pkg::mpu_operand_t o1,
  input  mpu_pkg::mpu_operand_t o2,
  input  mpu_pkg::mpu_operand_t o3,
  output logic                  test_true
);

  import mpu_pkg::*;

  mpu_operand_t opnd [4];
  logic [63:0]  mask;
  logic [63:0]  m [4]; // Masked operand values.

  assign opnd[0] = o0;
  assign opnd[1] = o1;
  assign opnd[2] = o2;
  assign opnd[3] = o3; // Usually the branch target.

  // Width from the size field.
  always_comb begin
    case (size)
      2'd0:    mask = 64'h0000_0000_0000_00ff;
      2'd1:    mask = 64'h0000_0000_0000_ffff;
      2'd2:    mask = 64'h0000_0000_ffff_ffff;
      default: mask = 64'hffff_ffff_ffff_ffff;
    endcase
  end

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      m[k] = opnd[k].value & mask;
    end
  end

  // Condition per opcode; anything else counts as true so no jump is taken.
  always_comb begin
    case (op)
      `MPU_OP_CMP:  test_true = (m[1] == m[2]);
      `MPU_OP_LT:   test_true = (m[0] < m[1]); // Unsigned.
      `MPU_OP_MASK: test_true = ((m[0] & m[1]) == m[2]);
      default:      test_true = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: mpu_execution.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpu_defines.svh"

module mpu_execution (
  input  logic                 clk,
  input  mpu_pkg::mpu_instr_t  instr,
  input  logic                 stalled,   // Read pending or interrupt up.
  input  logic [63:0]          hm_data,
  input  logic                 hm_done,
  output mpu_pkg::mpu_wreg_t   wreg,
  output mpu_pkg::mpu_ip_cmd_t ip_cmd,
  output logic [63:0]          hm_addr,
  output logic                 hm_start,
  output logic                 irq_set,
  output logic [63:0]          user_data
);

  logic is_load;
  logic is_mload;
  logic is_int;
  logic is_jmp;
  logic is_cond;   // One of the compare and branch forms.
  logic test_true;

  assign is_load  = (instr.op == `MPU_OP_LOAD);
  assign is_mload = (instr.op == `MPU_OP_MLOAD);
  assign is_int   = (instr.op == `MPU_OP_INT);
  assign is_jmp   = (instr.op == `MPU_OP_JMP);
  assign is_cond  = (instr.op == `MPU_OP_CMP) || (instr.op == `MPU_OP_LT) ||
                    (instr.op == `MPU_OP_MASK);

  mpu_alu alu (
    .size      (instr.size),
    .op        (instr.op),
    .o0        (instr.opnd[0]),
    .o1        (instr.opnd[1]),
    .o2        (instr.opnd[2]),
    .o3        (instr.opnd[3]),
    .test_true (test_true)
  );

  // Host read request, once per MLOAD.
  assign hm_addr  = instr.opnd[1].value;
  assign hm_start = is_mload & ~stalled; // Stall follows at the next edge.

  // Interrupt raise and its payload, kept while user_irq is up.
  assign irq_set = is_int & ~stalled;

  always_ff @(posedge clk) begin
    if (irq_set) begin
      user_data <= instr.opnd[0].value;
    end
  end

  // Register write, whole register.
  always_comb begin
    wreg.idx  = instr.opnd[0].idx;                          // Destination.
    wreg.data = is_mload ? hm_data : instr.opnd[1].value;
    wreg.we   = is_mload ? hm_done : (is_load & ~stalled);  // MLOAD lands on done.
  end

  // Next ip. Compares branch when the test fails.
  always_comb begin
    ip_cmd.ip_incr = instr.isize;
    ip_cmd.ip_load = is_jmp | (is_cond & ~test_true);
    case (instr.op)
      `MPU_OP_CMP, `MPU_OP_MASK: ip_cmd.ip_data = instr.opnd[3].value[15:0];
      `MPU_OP_LT:                ip_cmd.ip_data = instr.opnd[2].value[15:0];
      default:                   ip_cmd.ip_data = instr.opnd[0].value[15:0]; // JMP.
    endcase
  end

endmodule

`default_nettype wire

// File: mpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpu_defines.svh"

module mpu_decode (
  input  logic [8*`MPU_WIN_BYTES-1:0] prog_data,
  output logic [4:0]                  rd_idx [4],
  input  logic [63:0]                 rd_data [4],
  output mpu_pkg::mpu_instr_t         instr
);

  import mpu_pkg::*;

  logic [7:0]   win [`MPU_WIN_BYTES]; // Window split into bytes.
  logic [3:0]   kind;                 // Operand kinds from byte 1.
  logic [3:0]   off [5];              // Byte offset of each operand, then the end.
  mpu_operand_t opnd [4];

  always_comb begin
    for (int b = 0; b < `MPU_WIN_BYTES; b++) begin
      win[b] = prog_data[8*b +: 8];
    end
  end

  assign kind = win[1][3:0];

  // Walk the kinds. A register takes one byte, an immediate two.
  always_comb begin
    off[0] = 4'd2;
    for (int k = 0; k < 4; k++) begin
      off[k+1] = off[k] + ((kind[k] == `MPU_KIND_IMM) ? 4'd2 : 4'd1);
    end
  end

  // Register file addresses, harmless for immediates.
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      rd_idx[k] = win[off[k]][4:0];
    end
  end

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      if (kind[k] == `MPU_KIND_IMM) begin
        opnd[k].value = {48'd0, win[off[k] + 4'd1], win[off[k]]}; // Zero extend.
        opnd[k].idx   = '0;
        opnd[k].sel   = '0;
      end else begin
        opnd[k].value = rd_data[k];
        opnd[k].idx   = win[off[k]][4:0];
        opnd[k].sel   = win[off[k]][7:5];
      end
    end
  end

  always_comb begin
    instr.op    = win[0][3:0];
    instr.size  = win[0][5:4];
    instr.isize = {12'd0, off[4]}; // Header plus operand bytes.
    for (int k = 0; k < 4; k++) begin
      instr.opnd[k] = opnd[k];
    end
  end

endmodule

`default_nettype wire

// File: mpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpu_defines.svh"

module mpu_regfile (
  input  logic               clk,
  input  logic               reset,
  input  logic [4:0]         rd_idx [4],
  output logic [63:0]        rd_data [4],
  input  mpu_pkg::mpu_wreg_t wreg
);

  logic [63:0] regs [`MPU_NREGS];

  // Single write port, all registers zero after reset.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < `MPU_NREGS; r++) begin
        regs[r] <= '0;
      end
    end else if (wreg.we) begin
      regs[wreg.idx] <= wreg.data;
    end
  end

  // Asynchronous reads. A write shows up the cycle after its edge.
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      rd_data[k] = regs[rd_idx[k]];
    end
  end

endmodule

`default_nettype wire

// File: mpu_ip_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module mpu_ip_ctl (
  input  logic                 clk,
  input  logic                 reset,
  input  mpu_pkg::mpu_ip_cmd_t ip_cmd,
  input  logic                 is_mload,  // MLOAD presented without stall.
  input  logic                 hm_done,
  input  logic                 irq_set,
  input  logic                 irq_clear,
  output logic [15:0]          ip,
  output logic                 stalled,
  output logic                 user_irq
);

  logic pending; // Host read in flight.
  logic advance; // Move ip at this edge.

  assign stalled = pending | user_irq;

  // A read moves on only with hm_done. Otherwise wait for irq and new reads.
  assign advance = pending ? hm_done : (~user_irq & ~is_mload);

  always_ff @(posedge clk) begin
    if (reset) begin
      ip       <= '0;
      pending  <= 1'b0;
      user_irq <= 1'b0;
    end else begin
      if (pending) begin
        pending <= ~hm_done;
      end else if (is_mload && !user_irq) begin
        pending <= 1'b1;
      end
      if (irq_set) begin
        user_irq <= 1'b1;
      end else if (irq_clear) begin
        user_irq <= 1'b0; // Next instruction runs one cycle later.
      end
      if (advance) begin
        ip <= ip_cmd.ip_load ? ip_cmd.ip_data : ip + ip_cmd.ip_incr;
      end
    end
  end

endmodule

`default_nettype wire

// File: mpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module mpu_core (
  input  logic        clk,
  input  logic        reset,
  output logic [15:0] prog_addr,
  input  logic [79:0] prog_data, // Ten bytes from prog_addr.
  output logic [63:0] hm_addr,
  output logic        hm_start,
  input  logic [63:0] hm_data,
  input  logic        hm_done,
  output logic        user_irq,
  output logic [63:0] user_data,
  input  logic        irq_clear
);

  import mpu_pkg::*;

  mpu_instr_t  instr;
  mpu_wreg_t   wreg;
  mpu_ip_cmd_t ip_cmd;
  logic [4:0]  rd_idx [4];
  logic [63:0] rd_data [4];
  logic        stalled;
  logic        irq_set;

  mpu_decode decode (
    .prog_data (prog_data),
    .rd_idx    (rd_idx),
    .rd_data   (rd_data),
    .instr     (instr)
  );

  mpu_regfile regfile (
    .clk     (clk),
    .reset   (reset),
    .rd_idx  (rd_idx),
    .rd_data (rd_data),
    .wreg    (wreg)
  );

  mpu_execution execution (
    .clk       (clk),
    .instr     (instr),
    .stalled   (stalled),
    .hm_data   (hm_data),
    .hm_done   (hm_done),
    .wreg      (wreg),
    .ip_cmd    (ip_cmd),
    .hm_addr   (hm_addr),
    .hm_start  (hm_start),
    .irq_set   (irq_set),
    .user_data (user_data)
  );

  // hm_start marks an MLOAD that ip control has not yet seen.
  mpu_ip_ctl ip_ctl (
    .clk       (clk),
    .reset     (reset),
    .ip_cmd    (ip_cmd),
    .is_mload  (hm_start),
    .hm_done   (hm_done),
    .irq_set   (irq_set),
    .irq_clear (irq_clear),
    .ip        (prog_addr),
    .stalled   (stalled),
    .user_irq  (user_irq)
  );

endmodule

`default_nettype wire

// File: mpu_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mpu_core_checker (
  input logic        clk,
  input logic        reset,
  input logic [15:0] prog_addr,
  input logic        hm_start,
  input logic        hm_done,
  input logic        user_irq,
  input logic        irq_clear
);

  int   fail_count = 0; // Failed assertions so far.
  logic read_open;      // From hm_start until hm_done, seen at the ports.

  always_ff @(posedge clk) begin
    if (reset) begin
      read_open <= 1'b0;
    end else if (hm_done) begin
      read_open <= 1'b0;
    end else if (hm_start) begin
      read_open <= 1'b1;
    end
  end

  // Host read request is a one-cycle pulse.
  start_pulse: assert property (@(posedge clk) disable iff (reset) hm_start |=> !hm_start)
    else begin
      fail_count++;
      $error("hm_start stayed high for two cycles");
    end

  // Ip frozen during a read or an interrupt, except at the edge that sees hm_done.
  ip_hold: assert property (@(posedge clk) disable iff (reset)
    (((hm_start || read_open) && !hm_done) || user_irq) |=> $stable(prog_addr))
    else begin
      fail_count++;
      $error("prog_addr moved during a stall");
    end

  irq_release: assert property (@(posedge clk) disable iff (reset)
    $fell(user_irq) |-> $past(irq_clear))
    else begin
      fail_count++;
      $error("user_irq fell without irq_clear"); // Only the host may drop it.
    end

endmodule

`default_nettype wire

// File: tb_mpu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpu_defines.svh"

module tb_mpu_core;

  localparam int TIMEOUT_CYCLES = 400; // About 15 instructions, 2 interrupts, 1 read, slack.
  localparam logic [63:0] DATA_XOR = 64'h5a5a_0f0f_c3c3_9696; // Host data is address XOR this.

  logic        clk;
  logic        reset;
  logic [15:0] prog_addr;
  logic [79:0] prog_data;
  logic [63:0] hm_addr;
  logic        hm_start;
  logic [63:0] hm_data;
  logic        hm_done;
  logic        user_irq;
  logic [63:0] user_data;
  logic        irq_clear;

  logic [7:0]  mem [256];       // Program bytes.
  logic [15:0] exp_next [256];  // Expected next ip per instruction address.
  logic [63:0] exp_value [256]; // INT payload or MLOAD address.
  logic [15:0] pc;              // Build pointer.
  logic [15:0] final_addr;
  logic [15:0] last_addr;
  logic        last_irq;
  logic [31:0] lfsr;
  logic [2:0]  wait_cnt;        // Cycles left until hm_done.
  logic [63:0] req_addr;
  logic [1:0]  irq_cnt;
  int          cycles;

  mpu_core UUT (.*);

  bind mpu_core mpu_core_checker chk (.*);

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "stopped at the first error");
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // Galois form.
  endfunction

  // Encode one instruction at pc. A taken branch lands just past a 7-byte JMP-to-self.
  task automatic add_instr(input logic [3:0] op, input logic [1:0] size, input logic [3:0] kinds,
                           input logic [15:0] v0, input logic [15:0] v1, input logic [15:0] v2,
                           input logic [15:0] v3, input logic taken, input logic [63:0] value);
    logic [15:0] v [4];
    logic [15:0] len;
    logic [15:0] p;
    int          tgt;
    v[0] = v0;
    v[1] = v1;
    v[2] = v2;
    v[3] = v3;
    len = 16'd2; // Opcode byte and kinds byte.
    for (int k = 0; k < 4; k++) begin
      len = len + (kinds[k] ? 16'd2 : 16'd1);
    end
    tgt = (op == `MPU_OP_LT) ? 2 : ((op == `MPU_OP_JMP) ? 0 : 3);
    if (taken) begin
      v[tgt] = pc + len + 16'd7;
    end else if (op == `MPU_OP_JMP) begin
      v[0] = pc; // Jump to self.
    end
    exp_next[pc[7:0]]  = taken ? v[tgt] : ((op == `MPU_OP_JMP) ? pc : pc + len);
    exp_value[pc[7:0]] = value;
    mem[pc[7:0]]       = {2'b00, size, op};
    mem[pc[7:0] + 8'd1] = {4'h0, kinds};
    p = pc + 16'd2;
    for (int k = 0; k < 4; k++) begin
      mem[p[7:0]] = v[k][7:0];
      if (kinds[k]) begin
        mem[p[7:0] + 8'd1] = v[k][15:8]; // Little endian immediate.
      end
      p = p + (kinds[k] ? 16'd2 : 16'd1);
    end
    pc = p;
  endtask

  always_comb begin
    for (int i = 0; i < `MPU_WIN_BYTES; i++) begin
      prog_data[8*i +: 8] = mem[prog_addr[7:0] + 8'(i)];
    end
  end

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Host memory. Latency of 1 to 4 cycles, two LFSR bits per read.
  always @(posedge clk) begin
    logic [1:0] pick;
    hm_done <= 1'b0;
    if (hm_start && !reset) begin
      assert (hm_addr == exp_value[prog_addr[7:0]]) else abort_run($sformatf(
        "MISMATCH hm_addr: got %h expected %h", hm_addr, exp_value[prog_addr[7:0]]));
      pick[0] = lfsr[0];
      lfsr = lfsr_step(lfsr);
      pick[1] = lfsr[0];
      lfsr = lfsr_step(lfsr);
      wait_cnt <= 3'd1 + pick;
      req_addr <= hm_addr;
    end else if (wait_cnt != 3'd0) begin
      wait_cnt <= wait_cnt - 3'd1;
      if (wait_cnt == 3'd1) begin
        hm_done <= 1'b1;
        hm_data <= req_addr ^ DATA_XOR;
      end
    end
  end

  // Host clears the interrupt after four cycles.
  always @(posedge clk) begin
    irq_clear <= 1'b0;
    if (reset) begin
      irq_cnt <= 2'd0;
    end else if (user_irq && !irq_clear) begin
      irq_cnt <= irq_cnt + 2'd1;
      if (irq_cnt == 2'd3) begin
        irq_clear <= 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run("timeout, the program never reached its final jump");
    end
  end

  // Sampled mid-cycle. Each ip change is checked against the table of the previous ip.
  always @(negedge clk) begin
    if (!reset) begin
      if (UUT.chk.fail_count != 0) begin
        abort_run("a protocol assertion in the checker failed");
      end
      if (prog_addr != last_addr) begin
        assert (prog_addr == exp_next[last_addr[7:0]]) else abort_run($sformatf(
          "MISMATCH prog_addr: got %h expected %h", prog_addr, exp_next[last_addr[7:0]]));
        if (mem[last_addr[7:0]][3:0] == `MPU_OP_INT) begin // Leaving an INT raises the irq.
          assert (user_irq && !last_irq) else abort_run("user_irq did not rise after an INT");
        end
      end
      if (user_irq && !last_irq) begin // The INT sits at the previous ip.
        assert (user_data == exp_value[last_addr[7:0]]) else abort_run($sformatf(
          "MISMATCH user_data: got %h expected %h", user_data, exp_value[last_addr[7:0]]));
      end
    end
    last_addr = prog_addr;
    last_irq  = user_irq;
  end

  initial begin
    reset     = 1'b1;
    irq_clear = 1'b0;
    hm_done   = 1'b0;
    hm_data   = 64'd0;
    wait_cnt  = 3'd0;
    req_addr  = 64'd0;
    irq_cnt   = 2'd0;
    cycles    = 0;
    lfsr      = 32'he5d5;
    last_addr = 16'd0;
    last_irq  = 1'b0;
    for (int a = 0; a < 256; a++) begin
      mem[a] = 8'h00;
    end
    pc = 16'd0;
    add_instr(`MPU_OP_LOAD, 2'd3, 4'b0010, 16'h0003, 16'h1234, 0, 0, 1'b0, 64'h0); // r3.
    add_instr(`MPU_OP_INT, 2'd3, 4'b0000, 16'h0003, 0, 0, 0, 1'b0, 64'h1234);
    add_instr(`MPU_OP_MLOAD, 2'd3, 4'b0010, 16'h0005, 16'h0bd0, 0, 0, 1'b0, 64'h0bd0);
    add_instr(`MPU_OP_INT, 2'd3, 4'b0000, 16'h0005, 0, 0, 0, 1'b0, 64'h0bd0 ^ DATA_XOR);
    // Size 8 compare, operands differ only above bit 7.
    add_instr(`MPU_OP_CMP, 2'd0, 4'b1110, 0, 16'h0155, 16'h0255, 0, 1'b0, 64'h0);
    add_instr(`MPU_OP_CMP, 2'd1, 4'b1110, 0, 16'h0155, 16'h0255, 0, 1'b1, 64'h0);
    add_instr(`MPU_OP_JMP, 2'd3, 4'b0001, 0, 0, 0, 0, 1'b0, 64'h0); // Trap.
    add_instr(`MPU_OP_LT, 2'd3, 4'b0111, 16'h0003, 16'h0010, 0, 0, 1'b0, 64'h0);
    add_instr(`MPU_OP_LT, 2'd3, 4'b0111, 16'h0010, 16'h0003, 0, 0, 1'b1, 64'h0);
    add_instr(`MPU_OP_JMP, 2'd3, 4'b0001, 0, 0, 0, 0, 1'b0, 64'h0);
    add_instr(`MPU_OP_MASK, 2'd3, 4'b1111, 16'h00f3, 16'h000f, 16'h0003, 0, 1'b0, 64'h0);
    add_instr(`MPU_OP_MASK, 2'd3, 4'b1111, 16'h00f3, 16'h000f, 16'h0005, 0, 1'b1, 64'h0);
    add_instr(`MPU_OP_JMP, 2'd3, 4'b0001, 0, 0, 0, 0, 1'b0, 64'h0);
    add_instr(`MPU_OP_JMP, 2'd3, 4'b0001, 0, 0, 0, 0, 1'b1, 64'h0); // Plain jump.
    add_instr(`MPU_OP_JMP, 2'd3, 4'b0001, 0, 0, 0, 0, 1'b0, 64'h0);
    final_addr = pc;
    add_instr(`MPU_OP_JMP, 2'd3, 4'b0001, 0, 0, 0, 0, 1'b0, 64'h0); // End of program.
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (prog_addr == 16'd0) else abort_run($sformatf(
      "MISMATCH prog_addr: got %h expected 0000", prog_addr));
    assert (!hm_start) else abort_run("hm_start is high right after reset");
    assert (!user_irq) else abort_run("user_irq is high right after reset");
    while (prog_addr != final_addr) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk); // Let the jump to self run.
    if (UUT.chk.fail_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      abort_run("a protocol assertion in the checker failed");
    end
  end

endmodule

`default_nettype wire

// File: mpu_core.f
+incdir+.
mpu_pkg.sv
mpu_alu.sv
mpu_execution.sv
mpu_decode.sv
mpu_regfile.sv
mpu_ip_ctl.sv
mpu_core.sv
mpu_core_checker.sv
tb_mpu_core.sv

// File: Bender.yml
package:
  name: mpu_core

sources:
  - include_dirs:
      - .
    files:
      - mpu_pkg.sv
      - mpu_alu.sv
      - mpu_execution.sv
      - mpu_decode.sv
      - mpu_regfile.sv
      - mpu_ip_ctl.sv
      - mpu_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - mpu_core_checker.sv
      - tb_mpu_core.sv
